// ==== source/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

  // One data word of the 4-bit core
  typedef logic [3:0] nibble_t;

  // Full 12-bit data bus address
  typedef logic [11:0] mem_addr_t;

  // Divider chain, bit 0 is 128 Hz and bit 7 is 1 Hz
  typedef logic [7:0] timer_count_t;

  // RAM occupies 0x000 up to but not including this address
  localparam mem_addr_t RAM_LIMIT = 12'h280;

  // Upper address nibble of the I/O page
  localparam logic [3:0] IO_PAGE = 4'hF;

  // Register offsets inside the I/O page
  localparam logic [7:0] IO_FACTOR      = 8'h00;
  localparam logic [7:0] IO_MASK        = 8'h10;
  localparam logic [7:0] IO_TIMER_LO    = 8'h20;
  localparam logic [7:0] IO_TIMER_HI    = 8'h21;
  localparam logic [7:0] IO_OSC         = 8'h70;
  localparam logic [7:0] IO_TIMER_RESET = 8'h76;

  // Decoder response state
  typedef enum logic {IDLE, RESPOND} decode_state_t;

endpackage

`default_nettype wire

// ==== source/bus_decoder.sv ====
`default_nettype none

module bus_decoder (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     mem_strobe,
  input  logic                     mem_write_en,
  input  periph_pkg::mem_addr_t    mem_addr,
  input  periph_pkg::nibble_t      mem_wdata,
  output periph_pkg::nibble_t      mem_rdata,
  output logic                     mem_rdata_valid,
  output logic                     ram_write,
  output logic                     ram_read,
  output logic [9:0]               ram_addr,
  output periph_pkg::nibble_t      ram_wdata,
  input  periph_pkg::nibble_t      ram_rdata,
  input  periph_pkg::timer_count_t timer_count,
  output logic                     timer_clear,
  input  periph_pkg::nibble_t      clock_factor,
  output periph_pkg::nibble_t      clock_mask,
  output logic                     factor_clear
);
  import periph_pkg::*;

  decode_state_t state;
  logic          is_ram;
  logic          is_io;
  logic [7:0]    io_offset;
  logic          read_strobe;
  logic          write_strobe;
  logic          timer_reset_hit;
  logic          factor_read_hit;
  nibble_t       osc_reg;
  nibble_t       reg_value;
  nibble_t       reg_rdata;
  logic          from_ram;

  // Address classification
  assign is_ram    = mem_addr < RAM_LIMIT;
  assign is_io     = mem_addr[11:8] == IO_PAGE;
  assign io_offset = mem_addr[7:0];

  assign read_strobe  = mem_strobe && !mem_write_en;
  assign write_strobe = mem_strobe && mem_write_en;

  // Bit 0 would reset the watchdog, which is not part of this block
  assign timer_reset_hit = write_strobe && is_io && io_offset == IO_TIMER_RESET && mem_wdata[1];
  assign factor_read_hit = read_strobe && is_io && io_offset == IO_FACTOR;

  // RAM port is driven straight from the bus
  assign ram_write = write_strobe && is_ram;
  assign ram_read  = read_strobe && is_ram;
  assign ram_addr  = mem_addr[9:0];
  assign ram_wdata = mem_wdata;

  // Write-only and unmapped I/O offsets read as zero
  always_comb begin
    reg_value = '0;
    if (is_io) begin
      case (io_offset)
        IO_FACTOR:   reg_value = clock_factor;
        IO_MASK:     reg_value = clock_mask;
        IO_TIMER_LO: reg_value = timer_count[3:0];
        IO_TIMER_HI: reg_value = timer_count[7:4];
        IO_OSC:      reg_value = osc_reg;
        default:     reg_value = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state        <= IDLE;
      clock_mask   <= '0;
      osc_reg      <= '0;
      timer_clear  <= 1'b0;
      factor_clear <= 1'b0;
    end else begin
      // Back-to-back reads stay in RESPOND
      state        <= read_strobe ? RESPOND : IDLE;
      timer_clear  <= timer_reset_hit;
      factor_clear <= factor_read_hit;
      if (write_strobe && is_io && io_offset == IO_MASK) begin
        clock_mask <= mem_wdata;
      end
      if (write_strobe && is_io && io_offset == IO_OSC) begin
        osc_reg <= mem_wdata;
      end
    end
  end

  // Register value is taken before any factor clear lands
  always_ff @(posedge clk) begin
    if (read_strobe) begin
      reg_rdata <= reg_value;
      from_ram  <= is_ram;
    end
  end

  assign mem_rdata       = from_ram ? ram_rdata : reg_rdata;
  assign mem_rdata_valid = state == RESPOND;

  // Every valid cycle answers a read strobed one cycle earlier
  assert property (@(posedge clk) disable iff (!reset_n)
    mem_rdata_valid |-> $past(read_strobe));

  // A factor clear always rides on the response of its factor read
  assert property (@(posedge clk) disable iff (!reset_n)
    factor_clear |-> mem_rdata_valid);

  // Timer clear comes from a write and never meets a response
  assert property (@(posedge clk) disable iff (!reset_n)
    timer_clear |-> !mem_rdata_valid);

endmodule

`default_nettype wire

// ==== source/nibble_ram.sv ====
`default_nettype none

module nibble_ram (
  input  logic                clk,
  input  logic                ram_write,
  input  logic                ram_read,
  input  logic [9:0]          ram_addr,
  input  periph_pkg::nibble_t ram_wdata,
  output periph_pkg::nibble_t ram_rdata
);
  import periph_pkg::*;

  localparam int RAM_DEPTH = 640;

  // 256 + 256 + 128 nibbles of data memory
  nibble_t mem [RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (ram_write) begin
      mem[ram_addr] <= ram_wdata;
    end
  end

  // Registered read port, holds its value between reads
  always_ff @(posedge clk) begin
    if (ram_read) begin
      ram_rdata <= mem[ram_addr];
    end
  end

  // Decoder must keep the top 384 indices out of the array
  assert property (@(posedge clk)
    (ram_write || ram_read) |-> ram_addr < RAM_DEPTH);

endmodule

`default_nettype wire

// ==== source/clock_timer.sv ====
`default_nettype none

module clock_timer #(
  parameter int TICKS_PER_128HZ = 4
) (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     timer_clear,
  output periph_pkg::timer_count_t timer_count
);

  localparam int PRESCALE_W = (TICKS_PER_128HZ > 1) ? $clog2(TICKS_PER_128HZ) : 1;

  logic [PRESCALE_W-1:0] prescaler;
  logic                  step;

  // Last prescaler cycle of one 128 Hz period
  assign step = prescaler == PRESCALE_W'(TICKS_PER_128HZ - 1);

  // Each count bit toggles at half the rate of the one below,
  // so the bits run at 128, 64, ... 1 Hz of the scaled base
  always_ff @(posedge clk) begin
    if (!reset_n || timer_clear) begin
      prescaler   <= '0;
      timer_count <= '0;
    end else begin
      if (step) begin
        prescaler   <= '0;
        timer_count <= timer_count + 1'b1;
      end else begin
        prescaler <= prescaler + 1'b1;
      end
    end
  end

  // Prescaler wraps before it reaches the period
  assert property (@(posedge clk) disable iff (!reset_n)
    prescaler < TICKS_PER_128HZ);

endmodule

`default_nettype wire

// ==== source/clock_interrupt.sv ====
`default_nettype none

module clock_interrupt (
  input  logic                     clk,
  input  logic                     reset_n,
  input  periph_pkg::timer_count_t timer_count,
  input  periph_pkg::nibble_t      clock_mask,
  input  logic                     factor_clear,
  output periph_pkg::nibble_t      clock_factor,
  output logic                     interrupt_req
);
  import periph_pkg::*;

  nibble_t tap_now;
  nibble_t tap_prev;
  nibble_t tap_fall;

  // Factor bits 0 to 3 watch 32, 8, 2 and 1 Hz
  assign tap_now = {timer_count[7], timer_count[6], timer_count[4], timer_count[2]};

  // Falling edges that the mask lets through
  assign tap_fall = tap_prev & ~tap_now & clock_mask;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tap_prev     <= '0;
      clock_factor <= '0;
    end else begin
      tap_prev <= tap_now;
      // A new edge in the clear cycle still sets its flag
      if (factor_clear) begin
        clock_factor <= tap_fall;
      end else begin
        clock_factor <= clock_factor | tap_fall;
      end
    end
  end

  assign interrupt_req = |(clock_factor & clock_mask);

  // A flag sets only where the mask was open in the cycle before
  assert property (@(posedge clk) disable iff (!reset_n)
    (clock_factor & ~$past(clock_factor) & ~$past(clock_mask)) == '0);

endmodule

`default_nettype wire

// ==== source/periph_top.sv ====
`default_nettype none

module periph_top #(
  parameter int TICKS_PER_128HZ = 4
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  mem_strobe,
  input  logic                  mem_write_en,
  input  periph_pkg::mem_addr_t mem_addr,
  input  periph_pkg::nibble_t   mem_wdata,
  output periph_pkg::nibble_t   mem_rdata,
  output logic                  mem_rdata_valid,
  output logic                  interrupt_req
);
  import periph_pkg::*;

  logic         ram_write;
  logic         ram_read;
  logic [9:0]   ram_addr;
  nibble_t      ram_wdata;
  nibble_t      ram_rdata;
  timer_count_t timer_count;
  logic         timer_clear;
  nibble_t      clock_factor;
  nibble_t      clock_mask;
  logic         factor_clear;

  bus_decoder i_decoder (
    .clk            (clk),
    .reset_n        (reset_n),
    .mem_strobe     (mem_strobe),
    .mem_write_en   (mem_write_en),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata),
    .mem_rdata      (mem_rdata),
    .mem_rdata_valid(mem_rdata_valid),
    .ram_write      (ram_write),
    .ram_read       (ram_read),
    .ram_addr       (ram_addr),
    .ram_wdata      (ram_wdata),
    .ram_rdata      (ram_rdata),
    .timer_count    (timer_count),
    .timer_clear    (timer_clear),
    .clock_factor   (clock_factor),
    .clock_mask     (clock_mask),
    .factor_clear   (factor_clear)
  );

  nibble_ram i_ram (
    .clk      (clk),
    .ram_write(ram_write),
    .ram_read (ram_read),
    .ram_addr (ram_addr),
    .ram_wdata(ram_wdata),
    .ram_rdata(ram_rdata)
  );

  // Small prescale lets simulation reach the slow bits quickly
  clock_timer #(
    .TICKS_PER_128HZ(TICKS_PER_128HZ)
  ) i_timer (
    .clk        (clk),
    .reset_n    (reset_n),
    .timer_clear(timer_clear),
    .timer_count(timer_count)
  );

  clock_interrupt i_interrupt (
    .clk          (clk),
    .reset_n      (reset_n),
    .timer_count  (timer_count),
    .clock_mask   (clock_mask),
    .factor_clear (factor_clear),
    .clock_factor (clock_factor),
    .interrupt_req(interrupt_req)
  );

endmodule

`default_nettype wire

// ==== bench/periph_checker.sv ====
`default_nettype none

module periph_checker (
  input logic                clk,
  input logic                reset_n,
  input logic                mem_strobe,
  input logic                mem_write_en,
  input periph_pkg::nibble_t mem_rdata,
  input logic                mem_rdata_valid,
  input logic                interrupt_req
);
  import periph_pkg::*;

  localparam int VALID_TIMEOUT = 10;

  // Reads in flight with the oldest in front
  string   name_q[$];
  nibble_t value_q[$];
  int      pass_count = 0;
  int      fail_count = 0;
  int      idle_cycles = 0;
  logic    read_strobed = 1'b0;

  function automatic int pending_reads();
    return name_q.size();
  endfunction

  task automatic expect_read(input string name, input nibble_t value);
    name_q.push_back(name);
    value_q.push_back(value);
  endtask

  task automatic compare_value(input string name, input nibble_t expected, input nibble_t actual);
    if (actual === expected) begin
      $display("PASSED %s expected %h actual %h", name, expected, actual);
      pass_count++;
    end else begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      fail_count++;
    end
  endtask

  // Request line is stable between edges
  task automatic check_irq(input string name, input logic expected);
    compare_value(name, {3'b000, expected}, {3'b000, interrupt_req});
  endtask

  always @(posedge clk) begin : watch_reads
    string   name;
    nibble_t expected;
    if (reset_n && mem_rdata_valid) begin
      idle_cycles = 0;
      if (name_q.size() == 0) begin
        $display("Read data came back with no read outstanding");
        fail_count++;
      end else begin
        name     = name_q.pop_front();
        expected = value_q.pop_front();
        if (!read_strobed) begin
          $display("%s read data did not arrive one cycle after its strobe", name);
          fail_count++;
        end else begin
          compare_value(name, expected, mem_rdata);
        end
      end
    end else if (name_q.size() != 0) begin
      idle_cycles++;
      if (idle_cycles >= VALID_TIMEOUT) begin
        name     = name_q.pop_front();
        expected = value_q.pop_front();
        $display("%s got no read data within %0d cycles", name, VALID_TIMEOUT);
        fail_count++;
        idle_cycles = 0;
      end
    end
    // Response is due on the next edge
    read_strobed = reset_n && mem_strobe && !mem_write_en;
  end

endmodule

`default_nettype wire

// ==== bench/periph_tb.sv ====
`default_nettype none

module periph_tb;
  import periph_pkg::*;

  localparam int DRIVE_DELAY  = 10;
  localparam int READ_TIMEOUT = 20;
  localparam int SWEEP_COUNT  = 32;
  localparam int SWEEP_STRIDE = 20;

  logic             clk;
  logic             reset_n;
  logic             mem_strobe;
  logic             mem_write_en;
  mem_addr_t        mem_addr;
  nibble_t          mem_wdata;
  nibble_t          mem_rdata;
  logic             mem_rdata_valid;
  logic             interrupt_req;
  int               fd;
  int               fields;
  int               setup_errors;
  logic             timed_out;
  logic [8*100-1:0] line_buf;
  string            name;
  string            op;
  mem_addr_t        f_addr;
  nibble_t          f_data;
  nibble_t          f_expect;
  logic [31:0]      rng_state;
  nibble_t          sweep_data [SWEEP_COUNT];

  periph_top #(.TICKS_PER_128HZ(4)) i_dut (
    .clk(clk), .reset_n(reset_n), .mem_strobe(mem_strobe), .mem_write_en(mem_write_en),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
    .mem_rdata_valid(mem_rdata_valid), .interrupt_req(interrupt_req)
  );

  periph_checker i_checker (
    .clk(clk), .reset_n(reset_n), .mem_strobe(mem_strobe), .mem_write_en(mem_write_en),
    .mem_rdata(mem_rdata), .mem_rdata_valid(mem_rdata_valid), .interrupt_req(interrupt_req)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Holds the strobe for one cycle from just after a rising edge
  task automatic strobe_bus(input logic write, input mem_addr_t addr, input nibble_t data);
    mem_strobe   = 1'b1;
    mem_write_en = write;
    mem_addr     = addr;
    mem_wdata    = data;
    @(posedge clk);
    #DRIVE_DELAY;
    mem_strobe   = 1'b0;
    mem_write_en = 1'b0;
  endtask

  task automatic wait_reads_done();
    int cycles;
    cycles = 0;
    while (i_checker.pending_reads() != 0 && cycles < READ_TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
    end
    if (i_checker.pending_reads() != 0) begin
      $display("Read responses still outstanding after %0d cycles", READ_TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  // Write all sweep addresses first, then read them back
  task automatic ram_sweep(input string base_name, input mem_addr_t base);
    for (int i = 0; i < SWEEP_COUNT; i++) begin
      rng_state     = xorshift(rng_state);
      sweep_data[i] = rng_state[3:0];
      strobe_bus(1'b1, base + mem_addr_t'(i * SWEEP_STRIDE), sweep_data[i]);
    end
    for (int i = 0; i < SWEEP_COUNT; i++) begin
      i_checker.expect_read($sformatf("%s_%0d", base_name, i), sweep_data[i]);
      strobe_bus(1'b0, base + mem_addr_t'(i * SWEEP_STRIDE), '0);
      wait_reads_done();
    end
  endtask

  task automatic run_step();
    if (op == "W") begin
      strobe_bus(1'b1, f_addr, f_data);
    end else if (op == "R") begin
      i_checker.expect_read(name, f_expect);
      strobe_bus(1'b0, f_addr, '0);
      wait_reads_done();
    end else if (op == "B") begin
      i_checker.expect_read({name, "_first"}, f_expect);
      i_checker.expect_read({name, "_second"}, f_expect);
      strobe_bus(1'b0, f_addr, '0);
      strobe_bus(1'b0, f_addr, '0);
      wait_reads_done();
    end else if (op == "I") begin
      i_checker.check_irq(name, f_expect[0]);
      @(posedge clk);
      #DRIVE_DELAY;
    end else if (op == "D") begin
      // Idle count sits in the address column
      repeat (f_addr) begin
        @(posedge clk);
        #DRIVE_DELAY;
      end
    end else if (op == "X") begin
      ram_sweep(name, f_addr);
    end else begin
      $display("Step %s has unknown operation %s", name, op);
      setup_errors++;
    end
  endtask

  initial begin
    clk          = 1'b0;
    reset_n      = 1'b0;
    mem_strobe   = 1'b0;
    mem_write_en = 1'b0;
    mem_addr     = '0;
    mem_wdata    = '0;
    setup_errors = 0;
    timed_out    = 1'b0;
    rng_state    = 32'h2024;
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    reset_n = 1'b1;
    fd = $fopen("bench/periph_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test data file bench/periph_testdata.txt");
      setup_errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line_buf = '0;
        if ($fgets(line_buf, fd) != 0) begin
          fields = $sscanf(line_buf, "%s %s %h %h %h", name, op, f_addr, f_data, f_expect);
          if (fields == 5 && name[0] != "#") begin
            run_step();
          end
        end
      end
      $fclose(fd);
    end
    repeat (2) @(posedge clk);
    $display("Tests run %0d, passed %0d, failed %0d",
             i_checker.pass_count + i_checker.fail_count,
             i_checker.pass_count, i_checker.fail_count);
    if (setup_errors == 0 && !timed_out && i_checker.fail_count == 0 &&
        i_checker.pass_count > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
source/periph_pkg.sv
source/bus_decoder.sv
source/nibble_ram.sv
source/clock_timer.sv
source/clock_interrupt.sv
source/periph_top.sv
bench/periph_checker.sv
bench/periph_tb.sv

// ==== bench/periph_testdata.txt ====
# name op addr data expect, all hex, D idles for addr cycles, I checks interrupt_req
# ops W write, R read, B two back-to-back reads, X random RAM sweep from addr
ram_w_000    W 000 5 0
ram_w_27f    W 27F A 0
ram_w_200    W 200 6 0
ram_r_000    R 000 0 5
ram_r_27f    R 27F 0 A
ram_sweep    X 010 0 0
unmap_w_280  W 280 F 0
unmap_w_e00  W E00 F 0
unmap_w_f30  W F30 F 0
unmap_r_280  R 280 0 0
unmap_r_e00  R E00 0 0
unmap_r_f30  R F30 0 0
alias_r_000  R 000 0 5
alias_r_200  R 200 0 6
timer_clear  W F76 2 0
timer_idle   D 08D 0 0
timer_lo     R F20 0 3
timer_hi     R F21 0 2
mask_w       W F10 8 0
mask_r       R F10 0 8
mask_b2b     B F10 0 8
mask_off     W F10 0 0
osc_w        W F70 C 0
osc_r        R F70 0 C
masked_idle  D 028 0 0
masked_irq   I 000 0 0
masked_fac   R F00 0 0
irq_timer    W F76 2 0
irq_gap      D 002 0 0
irq_mask     W F10 1 0
irq_idle     D 022 0 0
irq_set      I 000 0 1
irq_factor   R F00 0 1
irq_cleared  I 000 0 0
irq_factor2  R F00 0 0
